// File: source/network_defines.svh
`ifndef NETWORK_DEFINES_SVH
`define NETWORK_DEFINES_SVH

// ========================================
// Network dimensions
// ========================================

`define NN_WIDTH        16    // Sample width in bits.
`define NN_INPUTS       15
`define NN_HIDDEN       6
`define NN_OUTPUTS      3

// ========================================
// APB register map
// ========================================

// Feature words sit one word apart at 4-byte steps.
`define NN_ADDR_FEATURE 8'h00
`define NN_ADDR_CONTROL 8'h40    // Bit 0 starts a frame.
`define NN_ADDR_STATUS  8'h44    // Bit 0 is done.
`define NN_ADDR_CLASS   8'h48
`define NN_ADDR_SCORE   8'h50    // Three scores follow.

`endif

// File: source/networkPkg.sv
`include "network_defines.svh"

package networkPkg;

	typedef logic signed [`NN_WIDTH-1:0] sample_t;

	typedef sample_t [`NN_INPUTS-1:0]  featureVec_t;
	typedef sample_t [`NN_HIDDEN-1:0]  hiddenVec_t;
	typedef sample_t [`NN_OUTPUTS-1:0] scoreVec_t;

	typedef logic [3:0] frameTag_t;    // Frame sequence number.

	// ========================================
	// Fixed weights
	// ========================================

	// Hidden layer, one row of weights per neuron.
	localparam sample_t [`NN_HIDDEN-1:0][`NN_INPUTS-1:0] hiddenWeights = '{
		'{ 12,  -7,  25,   3, -18,  30,  -4,   9, -22,  14,   6, -11,  19,  -2,  27},
		'{-15,  21,   8, -29,   4,  11,  33,  -6,  17, -24,   2,  13,  -9,  28,  -3},
		'{  7,  16, -20,  24,  -1, -13,   5,  31,  -8,  10, -26,  18,   3, -14,  22},
		'{ -5, -19,  14,   6,  27,  -3, -17,  12,  35, -10,   9, -23,  20,   1, -12},
		'{ 18,   2,  -9, -16,  11,  26, -21,  -4,   7,  29, -15,   5, -27,  13,   8},
		'{ -2,  28,  19, -11, -23,   8,  15, -30,   3,  16,  24,  -7,  10, -18,   6}
	};

	localparam sample_t [`NN_HIDDEN-1:0] hiddenBias = '{-10, 25, 4, -7, 13, 0};

	// Output layer.
	localparam sample_t [`NN_OUTPUTS-1:0][`NN_HIDDEN-1:0] outputWeights = '{
		'{ 14,  -9,  21,   6, -17,  11},
		'{ -6,  19, -12,  25,   8,  -3},
		'{ 10,   4, -15,  -7,  22,  17}
	};

	localparam sample_t [`NN_OUTPUTS-1:0] outputBias = '{3, -8, 12};

endpackage

// File: source/layerLink.sv
`timescale 1ns/1ps
`include "network_defines.svh"

interface layerLink #(
	parameter type payloadType = logic
) (
	input logic clk
);
	import networkPkg::*;

	logic       valid;    // One frame per cycle with no back-pressure.
	frameTag_t  tag;
	payloadType payload;

	modport source (input clk, output valid, output tag, output payload);
	modport sink (input clk, input valid, input tag, input payload);

endinterface

// File: source/apbFrontEnd.sv
`timescale 1ns/1ps
`include "network_defines.svh"

module apbFrontEnd (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [7:0]             paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	layerLink.source               featureLink,
	input  logic                   resultValid,
	input  networkPkg::frameTag_t  resultTag,
	input  logic [1:0]             resultClass,
	input  networkPkg::scoreVec_t  resultScores
);
	import networkPkg::*;

	featureVec_t features;
	scoreVec_t   lastScores;
	logic [1:0]  lastClass;
	frameTag_t   nextTag;
	logic        done;

	logic        setupPhase;
	logic        accessWrite;
	logic        startFrame;
	logic        addrMapped;
	logic        addrReadOnly;
	logic        addrFeature;
	logic [31:0] readData;
	logic [7:0]  featureOffset;
	logic [7:0]  scoreOffset;

	function automatic logic [31:0] signExtend(input sample_t value);
		return {{(32 - `NN_WIDTH){value[`NN_WIDTH-1]}}, value};
	endfunction

	// ========================================
	// Address decode
	// ========================================

	assign featureOffset = paddr - `NN_ADDR_FEATURE;
	assign scoreOffset = paddr - `NN_ADDR_SCORE;

	always_comb
	begin
		addrMapped = 1'b0;
		addrReadOnly = 1'b0;
		addrFeature = 1'b0;
		readData = '0;
		if (paddr[1:0] == 2'b00)
		begin
			if (featureOffset < 8'(4 * `NN_INPUTS))
			begin
				addrMapped = 1'b1;
				addrFeature = 1'b1;
				readData = signExtend(features[featureOffset[5:2]]);
			end
			else if (paddr == `NN_ADDR_CONTROL)
				addrMapped = 1'b1;    // Reads back as zero.
			else if (paddr == `NN_ADDR_STATUS)
			begin
				addrMapped = 1'b1;
				addrReadOnly = 1'b1;
				readData = {31'b0, done};
			end
			else if (paddr == `NN_ADDR_CLASS)
			begin
				addrMapped = 1'b1;
				addrReadOnly = 1'b1;
				readData = {30'b0, lastClass};
			end
			else if (scoreOffset < 8'(4 * `NN_OUTPUTS))
			begin
				addrMapped = 1'b1;
				addrReadOnly = 1'b1;
				readData = signExtend(lastScores[scoreOffset[3:2]]);
			end
		end
	end

	assign setupPhase = psel && !penable;
	assign accessWrite = psel && penable && pwrite && addrMapped && !addrReadOnly;
	assign startFrame = accessWrite && (paddr == `NN_ADDR_CONTROL) && pwdata[0];
	assign pready = 1'b1;

	// ========================================
	// APB response and registers
	// ========================================

	// Response is set up on the setup edge and holds through the access phase.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prdata <= '0;
			pslverr <= 1'b0;
		end
		else
		begin
			if (setupPhase && !pwrite)
				prdata <= readData;
			pslverr <= setupPhase && (!addrMapped || (pwrite && addrReadOnly));
		end
	end

	always_ff @(posedge clk)
	begin
		if (accessWrite && addrFeature)
			features[featureOffset[5:2]] <= pwdata[`NN_WIDTH-1:0];
		if (startFrame)
			featureLink.payload <= features;    // Snapshot for the pipeline.
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featureLink.valid <= 1'b0;
			featureLink.tag <= '0;
			nextTag <= '0;
			done <= 1'b0;
			lastClass <= '0;
			lastScores <= '0;
		end
		else
		begin
			featureLink.valid <= startFrame;
			if (startFrame)
			begin
				featureLink.tag <= nextTag;
				nextTag <= nextTag + 1'b1;
			end
			if (resultValid)
			begin
				lastClass <= resultClass;
				lastScores <= resultScores;
			end
			// Done tracks the most recently launched frame.
			if (startFrame)
				done <= 1'b0;
			else if (resultValid && resultTag == featureLink.tag)
				done <= 1'b1;
		end
	end

endmodule

// File: source/neuronNode.sv
`timescale 1ns/1ps
`include "network_defines.svh"

module neuronNode #(
	parameter int                              FANIN   = 1,
	parameter networkPkg::sample_t [FANIN-1:0] WEIGHTS = '0,
	parameter networkPkg::sample_t             BIAS    = '0
) (
	input  logic                              clk,
	input  logic                              reset,
	input  networkPkg::sample_t [FANIN-1:0]   inputs,
	output networkPkg::sample_t               activation
);
	import networkPkg::*;

	sample_t [FANIN-1:0] inputReg;
	sample_t             sumReg;
	sample_t             weightedSum;

	// Products and sum wrap at the sample width.
	always_comb
	begin
		weightedSum = BIAS;
		for (int i = 0; i < FANIN; i++)
			weightedSum = sample_t'(weightedSum + inputReg[i] * WEIGHTS[i]);
	end

	// ========================================
	// Input, sum and ReLU stages
	// ========================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inputReg <= inputs;
			sumReg <= weightedSum;
			if (sumReg[`NN_WIDTH-1])
				activation <= '0;    // Negative sum clamps to zero.
			else
				activation <= sumReg;
		end
	end

endmodule

// File: source/denseLayer.sv
`timescale 1ns/1ps
`include "network_defines.svh"

module denseLayer #(
	parameter type inType  = logic,
	parameter type outType = logic,
	parameter int  FANIN   = 1,
	parameter int  FANOUT  = 1,
	parameter networkPkg::sample_t [FANOUT-1:0][FANIN-1:0] WEIGHTS = '0,
	parameter networkPkg::sample_t [FANOUT-1:0]            BIAS    = '0
) (
	input logic      clk,
	input logic      reset,
	layerLink.sink   inLink,
	layerLink.source outLink
);
	import networkPkg::*;

	localparam int LATENCY = 3;    // Matches the neuron pipeline.

	sample_t [FANIN-1:0]  inSamples;
	sample_t [FANOUT-1:0] activations;
	logic [LATENCY-1:0]   validPipe;
	frameTag_t            tagPipe [LATENCY];

	assign inSamples = inType'(inLink.payload);

	// ========================================
	// Neuron row
	// ========================================

	for (genvar n = 0; n < FANOUT; n++)
	begin : gNeuron
		neuronNode #(
			.FANIN   (FANIN),
			.WEIGHTS (WEIGHTS[n]),
			.BIAS    (BIAS[n])
		) node (
			.clk        (clk),
			.reset      (reset),
			.inputs     (inSamples),
			.activation (activations[n])
		);
	end

	// Frame valid and tag follow the data.
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[LATENCY-2:0], inLink.valid};
	end

	always_ff @(posedge clk)
	begin
		tagPipe[0] <= inLink.tag;
		for (int s = 1; s < LATENCY; s++)
			tagPipe[s] <= tagPipe[s-1];
	end

	assign outLink.valid = validPipe[LATENCY-1];
	assign outLink.tag = tagPipe[LATENCY-1];
	assign outLink.payload = outType'(activations);

endmodule

// File: source/classSelect.sv
`timescale 1ns/1ps
`include "network_defines.svh"

module classSelect (
	input  logic                  clk,
	input  logic                  reset,
	layerLink.sink                scoreIn,
	output logic                  resultValid,
	output networkPkg::frameTag_t resultTag,
	output logic [1:0]            resultClass,
	output networkPkg::scoreVec_t resultScores
);
	import networkPkg::*;

	logic [1:0] bestIndex;
	sample_t    bestScore;

	// Strict compare keeps the lowest index on a tie.
	always_comb
	begin
		bestIndex = '0;
		bestScore = scoreIn.payload[0];
		for (int i = 1; i < `NN_OUTPUTS; i++)
		begin
			if (scoreIn.payload[i] > bestScore)
			begin
				bestIndex = 2'(i);
				bestScore = scoreIn.payload[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= scoreIn.valid;
	end

	always_ff @(posedge clk)
	begin
		resultTag <= scoreIn.tag;
		resultClass <= bestIndex;
		resultScores <= scoreIn.payload;
	end

endmodule

// File: source/neuralNetTop.sv
`timescale 1ns/1ps
`include "network_defines.svh"

module neuralNetTop (
	input  logic        clk,
	input  logic        reset,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);
	import networkPkg::*;

	layerLink #(.payloadType(featureVec_t)) featureLink (.clk(clk));
	layerLink #(.payloadType(hiddenVec_t))  hiddenLink (.clk(clk));
	layerLink #(.payloadType(scoreVec_t))   scoreLink (.clk(clk));

	logic       resultValid;
	frameTag_t  resultTag;
	logic [1:0] resultClass;
	scoreVec_t  resultScores;

	apbFrontEnd frontEnd (
		.clk          (clk),
		.reset        (reset),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.featureLink  (featureLink),
		.resultValid  (resultValid),
		.resultTag    (resultTag),
		.resultClass  (resultClass),
		.resultScores (resultScores)
	);

	// ========================================
	// Pipeline of 7 cycles from start to result
	// ========================================

	denseLayer #(
		.inType  (featureVec_t),
		.outType (hiddenVec_t),
		.FANIN   (`NN_INPUTS),
		.FANOUT  (`NN_HIDDEN),
		.WEIGHTS (hiddenWeights),
		.BIAS    (hiddenBias)
	) hiddenLayer (
		.clk     (clk),
		.reset   (reset),
		.inLink  (featureLink),
		.outLink (hiddenLink)
	);

	denseLayer #(
		.inType  (hiddenVec_t),
		.outType (scoreVec_t),
		.FANIN   (`NN_HIDDEN),
		.FANOUT  (`NN_OUTPUTS),
		.WEIGHTS (outputWeights),
		.BIAS    (outputBias)
	) outputLayer (
		.clk     (clk),
		.reset   (reset),
		.inLink  (hiddenLink),
		.outLink (scoreLink)
	);

	classSelect selector (
		.clk          (clk),
		.reset        (reset),
		.scoreIn      (scoreLink),
		.resultValid  (resultValid),
		.resultTag    (resultTag),
		.resultClass  (resultClass),
		.resultScores (resultScores)
	);

endmodule

// File: bench/neuralNet_chk.sv
`timescale 1ns/1ps

module neuralNet_chk (
	input logic                  clk,
	input logic                  reset,
	input logic                  psel,
	input logic                  penable,
	input logic                  featureValid,
	input networkPkg::frameTag_t featureTag,
	input logic                  resultValid,
	input networkPkg::frameTag_t resultTag,
	input logic                  done
);
	localparam int pipeLatency = 7;    // Start edge to result edge.

	// ========================================
	// APB and pipeline properties
	// ========================================

	penableAfterSetup: assert property (@(posedge clk) disable iff (reset)
		penable |-> ($past(psel) && !$past(penable)))
		else $error("penable high without a setup phase on the cycle before");

	resultLatency: assert property (@(posedge clk) disable iff (reset)
		resultValid == $past(featureValid, pipeLatency))
		else $error("resultValid does not follow featureLink valid by 7 cycles");

	resultTagKept: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> (resultTag == $past(featureTag, pipeLatency)))
		else $error("result tag differs from the launched tag");

	// Done is set from the registered result.
	doneFromResult: assert property (@(posedge clk) disable iff (reset)
		$rose(done) |-> $past(resultValid))
		else $error("done rose without a result");

endmodule

// File: bench/neuralNetTb.sv
`timescale 1ns/1ps
`include "network_defines.svh"

module neuralNetTb;
	import networkPkg::*;

	typedef enum logic [1:0] {opWrite, opRead, opWaitDone} txnOp_t;

	typedef struct packed {
		txnOp_t      op;
		logic [7:0]  addr;
		logic [31:0] wdata;
		logic [31:0] expData;
		logic        expErr;
	} txnRow_t;

	localparam int cyclesPerRow = 40;
	localparam int maxPolls = 10;
	localparam int pipeLatency = 7;
	localparam int randomFrames = 20;

	logic        clk;
	logic        reset;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	txnRow_t transactions[$];
	logic    tableReady;
	int      watchdogCycles;
	int      cycleCount;
	int      accessCycle;    // Cycle count just before the last access edge.
	int      startCycle;

	neuralNetTop i_dut (
		.clk     (clk),
		.reset   (reset),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	bind neuralNetTop neuralNet_chk protocolCheck (
		.clk          (clk),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.featureValid (featureLink.valid),
		.featureTag   (featureLink.tag),
		.resultValid  (resultValid),
		.resultTag    (resultTag),
		.done         (frontEnd.done)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	// ========================================
	// Reporting and APB access
	// ========================================

	task automatic reportMismatch(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		$display("** Error at %0t ns: %s got 0x%08h, expected 0x%08h", $time, what, got, expected);
		$display("Simulation FAILED");
		$fatal(1, "Value check failed");
	endtask

	task automatic reportFailure(input string text);
		$display("%s at %0t ns", text, $time);
		$display("Simulation FAILED");
		$fatal(1, "Check failed");
	endtask

	task automatic apbTransfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		accessCycle = cycleCount;
		rdata = prdata;    // Stable since the setup edge.
		err = pslverr;
		assert (pready) else reportMismatch("pready in access phase", 32'(pready), 32'h1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// ========================================
	// Reference model
	// ========================================

	function automatic sample_t relu(input sample_t v);
		return (v < sample_t'(0)) ? '0 : v;
	endfunction

	function automatic logic [31:0] wordOf(input sample_t s);
		return 32'(s);
	endfunction

	function automatic void referenceModel(input featureVec_t f, output scoreVec_t scores,
		output logic [1:0] cls);
		hiddenVec_t hidden;
		int         acc;
		for (int n = 0; n < `NN_HIDDEN; n++)
		begin
			acc = int'(hiddenBias[n]);
			for (int i = 0; i < `NN_INPUTS; i++)
				acc += int'(f[i]) * int'(hiddenWeights[n][i]);
			hidden[n] = relu(sample_t'(acc));    // Only the low 16 bits survive.
		end
		for (int k = 0; k < `NN_OUTPUTS; k++)
		begin
			acc = int'(outputBias[k]);
			for (int n = 0; n < `NN_HIDDEN; n++)
				acc += int'(hidden[n]) * int'(outputWeights[k][n]);
			scores[k] = relu(sample_t'(acc));
		end
		cls = '0;
		for (int k = 1; k < `NN_OUTPUTS; k++)
			if (scores[k] > scores[cls])
				cls = 2'(k);
	endfunction

	// ========================================
	// Transaction table
	// ========================================

	task automatic addRow(input txnOp_t op, input logic [7:0] addr, input logic [31:0] wdata,
		input logic [31:0] expData, input logic expErr);
		transactions.push_back('{op, addr, wdata, expData, expErr});
	endtask

	task automatic addFrame(input featureVec_t f);
		scoreVec_t  scores;
		logic [1:0] winner;
		referenceModel(f, scores, winner);
		for (int i = 0; i < `NN_INPUTS; i++)
			addRow(opWrite, 8'(`NN_ADDR_FEATURE + 4 * i), wordOf(f[i]), '0, 1'b0);
		addRow(opWrite, `NN_ADDR_CONTROL, 32'h1, '0, 1'b0);
		addRow(opRead, `NN_ADDR_STATUS, '0, 32'h0, 1'b0);    // Start clears done.
		addRow(opWaitDone, `NN_ADDR_STATUS, '0, 32'h1, 1'b0);
		addRow(opRead, `NN_ADDR_CLASS, '0, {30'b0, winner}, 1'b0);
		for (int k = 0; k < `NN_OUTPUTS; k++)
			addRow(opRead, 8'(`NN_ADDR_SCORE + 4 * k), '0, wordOf(scores[k]), 1'b0);
	endtask

	task automatic buildTable();
		featureVec_t frame;
		logic [15:0] pattern;
		addRow(opRead, `NN_ADDR_STATUS, '0, '0, 1'b0);    // Result registers after reset.
		addRow(opRead, `NN_ADDR_CLASS, '0, '0, 1'b0);
		for (int k = 0; k < `NN_OUTPUTS; k++)
			addRow(opRead, 8'(`NN_ADDR_SCORE + 4 * k), '0, '0, 1'b0);
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			pattern = 16'(16'h0F0F * (i + 1));
			addRow(opWrite, 8'(`NN_ADDR_FEATURE + 4 * i), {16'hA5A5, pattern}, '0, 1'b0);
		end
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			pattern = 16'(16'h0F0F * (i + 1));
			addRow(opRead, 8'(`NN_ADDR_FEATURE + 4 * i), '0, wordOf(sample_t'(pattern)), 1'b0);
		end
		addRow(opWrite, `NN_ADDR_CONTROL, 32'h0, '0, 1'b0);
		addRow(opRead, `NN_ADDR_CONTROL, '0, '0, 1'b0);
		addRow(opRead, 8'h3C, '0, '0, 1'b1);
		addRow(opRead, 8'h5C, '0, '0, 1'b1);
		addRow(opRead, 8'h41, '0, '0, 1'b1);
		addRow(opWrite, `NN_ADDR_STATUS, 32'h1, '0, 1'b1);
		addRow(opWrite, `NN_ADDR_CLASS, 32'h2, '0, 1'b1);
		addRow(opWrite, `NN_ADDR_SCORE, 32'h5, '0, 1'b1);
		frame = '0;    // Outputs come from the biases alone.
		addFrame(frame);
		for (int i = 0; i < `NN_INPUTS; i++)
			frame[i] = sample_t'(i * 37 - 200);
		addFrame(frame);
		for (int i = 0; i < `NN_INPUTS; i++)
			frame[i] = 16'h7FFF;
		addFrame(frame);
		for (int i = 0; i < `NN_INPUTS; i++)
			frame[i] = (i % 2 == 0) ? 16'h8000 : 16'h7FFF;
		addFrame(frame);
		for (int r = 0; r < randomFrames; r++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
				frame[i] = sample_t'($urandom);
			addFrame(frame);
		end
	endtask

	task automatic applyRow(input txnRow_t row, input int index);
		logic [31:0] rdata;
		logic        err;
		int          polls;
		int          elapsed;
		string       where;
		where = $sformatf("row %0d addr 0x%02h", index, row.addr);
		case (row.op)
			opWrite:
			begin
				apbTransfer(1'b1, row.addr, row.wdata, rdata, err);
				if (row.addr == `NN_ADDR_CONTROL && row.wdata[0])
					startCycle = accessCycle;
			end
			opRead:
			begin
				apbTransfer(1'b0, row.addr, '0, rdata, err);
				assert (rdata == row.expData)
					else reportMismatch($sformatf("%s read data", where), rdata, row.expData);
			end
			default:
			begin
				polls = 0;
				rdata = '0;
				err = 1'b0;
				while (!rdata[0] && polls < maxPolls)
				begin
					apbTransfer(1'b0, row.addr, '0, rdata, err);
					polls++;
				end
				assert (rdata[0])
					else reportFailure($sformatf("Done still low after %0d status polls", polls));
				elapsed = cycleCount - startCycle - 1;
				assert (elapsed >= pipeLatency)
					else reportFailure($sformatf("Done set only %0d cycles after start", elapsed));
				assert (rdata == row.expData)
					else reportMismatch($sformatf("%s status", where), rdata, row.expData);
			end
		endcase
		assert (err == row.expErr)
			else reportMismatch($sformatf("%s pslverr", where), 32'(err), 32'(row.expErr));
	endtask

	// ========================================
	// Main sequence and watchdog
	// ========================================

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		cycleCount = 0;
		accessCycle = 0;
		startCycle = 0;
		tableReady = 1'b0;
		void'($urandom(32'h7e39e741));
		buildTable();
		watchdogCycles = (transactions.size() + 3) * cyclesPerRow;
		tableReady = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		foreach (transactions[r])
			applyRow(transactions[r], r);
		$display("Simulation PASSED");
		$finish;
	end

	initial
	begin
		wait (tableReady);
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run is stuck", watchdogCycles);
		$display("Simulation FAILED");
		$fatal(1, "Timeout");
	end

endmodule

// File: flist.f
+incdir+source
source/networkPkg.sv
source/layerLink.sv
source/apbFrontEnd.sv
source/neuronNode.sv
source/denseLayer.sv
source/classSelect.sv
source/neuralNetTop.sv
bench/neuralNet_chk.sv
bench/neuralNetTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module neuralNetTb -o neuralNetSim &&
./obj_dir/neuralNetSim || exit 1
